// File: verilog/w_buffer_pkg.sv
// AXI4 write-data buffer package
// Holds the fixed channel widths, the W beat and translation decision
// types, and small helpers for building and classifying decisions

package w_buffer_pkg;

  // W channel and transaction widths
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
  localparam int unsigned USER_WIDTH = 4;
  localparam int unsigned ID_WIDTH   = 4;

  // One W beat, 41 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic [USER_WIDTH-1:0] user;
    logic                  last;
  } w_beat_t;

  // One translation decision for a whole burst, 9 bits
  typedef struct packed {
    logic                accept;
    logic                drop;
    logic                master;
    logic [ID_WIDTH-1:0] id;
    logic                prefetch;
    logic                hit;
  } decision_t;

  // Gathers the separate translation outputs into one decision
  function automatic decision_t make_decision(
    input logic                accept,
    input logic                drop,
    input logic                master,
    input logic [ID_WIDTH-1:0] id,
    input logic                prefetch,
    input logic                hit
  );
    decision_t dec;
    dec.accept   = accept;
    dec.drop     = drop;
    dec.master   = master;
    dec.id       = id;
    dec.prefetch = prefetch;
    dec.hit      = hit;
    return dec;
  endfunction

  // A decision is a real request only when it accepts or drops
  function automatic logic decision_is_req(input decision_t dec);
    return dec.accept | dec.drop;
  endfunction

endpackage

// File: verilog/w_beat_if.sv
// W beat stream interface
// Carries one W beat with valid/ready between the input FIFO and
// the routing control

`timescale 1ns/1ps

interface w_beat_if
  import w_buffer_pkg::*;
();

  // Beat payload, held stable while valid is high and ready is low
  w_beat_t beat;
  logic    valid;
  logic    ready;

  // Input FIFO side
  modport source (
    output beat,
    output valid,
    input  ready
  );

  // Routing control side
  modport sink (
    input  beat,
    input  valid,
    output ready
  );

endinterface

// File: verilog/w_stream_fifo.sv
// Valid/ready stream FIFO
// Circular buffer with read and write pointers and an occupancy count.
// Entries become visible one cycle after the push, no bypass

`timescale 1ns/1ps

module w_stream_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         payload_t = logic [7:0]
) (
  input  logic     axi4_aclk,
  input  logic     axi4_arstn,

  // Push side
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,

  // Pop side
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Pointer advance with wrap, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Ready only drops when every slot is taken
  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // Storage array
  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
    end
  end

  // Occupancy, unchanged when push and pop meet in one cycle
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      count_q <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: verilog/w_route_ctrl.sv
// W routing control
// Forwards or discards the burst at the head of the beat stream according
// to the head translation decision, and runs the drop handshake with the
// B-response sender

`timescale 1ns/1ps

module w_route_ctrl
  import w_buffer_pkg::*;
(
  input  logic                axi4_aclk,
  input  logic                axi4_arstn,

  // Beat stream from the input FIFO
  w_beat_if.sink              beat,

  // Head decision from the decision FIFO
  input  logic                dec_valid_i,
  input  decision_t           dec_i,
  output logic                dec_ready_o,

  // Master W channel
  output w_beat_t             m_beat_o,
  output logic                m_valid_o,
  input  logic                m_ready_i,
  output logic                master_select_o,

  // B sender handshake
  output logic                b_drop_o,
  input  logic                b_done_i,
  output logic [ID_WIDTH-1:0] id_o,
  output logic                prefetch_o,
  output logic                hit_o
);

  logic b_drop_q;
  logic b_drop_set;
  logic w_done;
  logic beat_xfer;

  assign beat_xfer = beat.valid & beat.ready;

  always_comb begin
    m_beat_o        = '0;
    m_valid_o       = 1'b0;
    master_select_o = 1'b0;
    beat.ready      = 1'b0;
    w_done          = 1'b0;
    b_drop_set      = 1'b0;

    if (dec_valid_i) begin
      if (dec_i.accept) begin
        // Link the beat stream straight through to the master port
        m_beat_o        = beat.beat;
        m_valid_o       = beat.valid;
        beat.ready      = m_ready_i;
        master_select_o = dec_i.master;
        w_done          = beat_xfer & beat.beat.last;
      end else if (!b_drop_q) begin
        // Throw the burst away, one beat per cycle
        beat.ready = 1'b1;
        b_drop_set = beat_xfer & beat.beat.last;
      end
    end
  end

  // Drop request toward the B sender, held until it answers
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      b_drop_q <= 1'b0;
    end else if (b_drop_q && b_done_i) begin
      b_drop_q <= 1'b0;
    end else if (b_drop_set) begin
      b_drop_q <= 1'b1;
    end
  end

  assign b_drop_o = b_drop_q;

  // Pop on the last forwarded beat or when the drop is acknowledged
  assign dec_ready_o = w_done | (b_drop_q & b_done_i);

  // Tags for the B sender always follow the head decision
  assign id_o       = dec_i.id;
  assign prefetch_o = dec_i.prefetch;
  assign hit_o      = dec_i.hit;

endmodule

// File: verilog/axi4_w_buffer.sv
// AXI4 write-data buffer
// Buffers W beats and per-burst translation decisions, then forwards
// accepted bursts to the master W channel and drops the rest with a
// handshake toward the B-response sender

`timescale 1ns/1ps

module axi4_w_buffer
  import w_buffer_pkg::*;
#(
  parameter int unsigned BEAT_FIFO_DEPTH     = 4,
  parameter int unsigned DECISION_FIFO_DEPTH = 8
) (
  input  logic                  axi4_aclk,
  input  logic                  axi4_arstn,

  // Translation unit
  input  logic                  l1_accept_i,
  input  logic                  l1_drop_i,
  input  logic                  l1_master_i,
  input  logic [ID_WIDTH-1:0]   l1_id_i,
  input  logic                  l1_prefetch_i,
  input  logic                  l1_hit_i,
  output logic                  l1_done_o,
  output logic                  input_stall_o,
  output logic                  master_select_o,

  // B sender
  output logic                  b_drop_o,
  input  logic                  b_done_i,
  output logic [ID_WIDTH-1:0]   id_o,
  output logic                  prefetch_o,
  output logic                  hit_o,

  // Slave W channel
  input  logic [DATA_WIDTH-1:0] s_axi4_wdata_i,
  input  logic [STRB_WIDTH-1:0] s_axi4_wstrb_i,
  input  logic                  s_axi4_wlast_i,
  input  logic [USER_WIDTH-1:0] s_axi4_wuser_i,
  input  logic                  s_axi4_wvalid_i,
  output logic                  s_axi4_wready_o,

  // Master W channel
  output logic [DATA_WIDTH-1:0] m_axi4_wdata_o,
  output logic [STRB_WIDTH-1:0] m_axi4_wstrb_o,
  output logic                  m_axi4_wlast_o,
  output logic [USER_WIDTH-1:0] m_axi4_wuser_o,
  output logic                  m_axi4_wvalid_o,
  input  logic                  m_axi4_wready_i
);

  w_beat_t   s_beat;
  w_beat_t   m_beat;
  decision_t l1_dec;
  decision_t head_dec;
  logic      dec_push_valid;
  logic      dec_push_ready;
  logic      dec_pop_valid;
  logic      dec_pop_ready;

  w_beat_if beat_bus ();

  assign s_beat.data = s_axi4_wdata_i;
  assign s_beat.strb = s_axi4_wstrb_i;
  assign s_beat.user = s_axi4_wuser_i;
  assign s_beat.last = s_axi4_wlast_i;

  w_stream_fifo #(
    .DEPTH     ( BEAT_FIFO_DEPTH ),
    .payload_t ( w_beat_t        )
  ) u_beat_fifo (
    .axi4_aclk    ( axi4_aclk       ),
    .axi4_arstn   ( axi4_arstn      ),
    .push_valid_i ( s_axi4_wvalid_i ),
    .push_data_i  ( s_beat          ),
    .push_ready_o ( s_axi4_wready_o ),
    .pop_valid_o  ( beat_bus.valid  ),
    .pop_data_o   ( beat_bus.beat   ),
    .pop_ready_i  ( beat_bus.ready  )
  );

  // Only accept or drop requests enter the decision FIFO
  assign l1_dec = make_decision(l1_accept_i, l1_drop_i, l1_master_i,
                                l1_id_i, l1_prefetch_i, l1_hit_i);
  assign dec_push_valid = decision_is_req(l1_dec);

  w_stream_fifo #(
    .DEPTH     ( DECISION_FIFO_DEPTH ),
    .payload_t ( decision_t          )
  ) u_decision_fifo (
    .axi4_aclk    ( axi4_aclk      ),
    .axi4_arstn   ( axi4_arstn     ),
    .push_valid_i ( dec_push_valid ),
    .push_data_i  ( l1_dec         ),
    .push_ready_o ( dec_push_ready ),
    .pop_valid_o  ( dec_pop_valid  ),
    .pop_data_o   ( head_dec       ),
    .pop_ready_i  ( dec_pop_ready  )
  );

  // Done pulses in the cycle the decision is taken
  assign l1_done_o     = dec_push_valid & dec_push_ready;
  assign input_stall_o = ~dec_push_ready;

  w_route_ctrl u_route_ctrl (
    .axi4_aclk       ( axi4_aclk       ),
    .axi4_arstn      ( axi4_arstn      ),
    .beat            ( beat_bus.sink   ),
    .dec_valid_i     ( dec_pop_valid   ),
    .dec_i           ( head_dec        ),
    .dec_ready_o     ( dec_pop_ready   ),
    .m_beat_o        ( m_beat          ),
    .m_valid_o       ( m_axi4_wvalid_o ),
    .m_ready_i       ( m_axi4_wready_i ),
    .master_select_o ( master_select_o ),
    .b_drop_o        ( b_drop_o        ),
    .b_done_i        ( b_done_i        ),
    .id_o            ( id_o            ),
    .prefetch_o      ( prefetch_o      ),
    .hit_o           ( hit_o           )
  );

  assign m_axi4_wdata_o = m_beat.data;
  assign m_axi4_wstrb_o = m_beat.strb;
  assign m_axi4_wuser_o = m_beat.user;
  assign m_axi4_wlast_o = m_beat.last;

endmodule

// File: verification/w_buffer_asserts.sv
// Protocol assertions for the W routing control
// Bound into w_route_ctrl, covers the drop handshake and master
// channel stability under back-pressure

`timescale 1ns/1ps

module w_buffer_asserts
  import w_buffer_pkg::*;
(
  input logic                axi4_aclk,
  input logic                axi4_arstn,
  input logic                m_valid_i,
  input logic                m_ready_i,
  input w_beat_t             m_beat_i,
  input logic                b_drop_i,
  input logic                b_done_i,
  input logic [ID_WIDTH-1:0] id_i,
  input logic                prefetch_i,
  input logic                hit_i
);

  // Drop request and its tags stay up until the B sender answers
  a_drop_hold: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (b_drop_i && !b_done_i) |=> (b_drop_i && $stable({id_i, prefetch_i, hit_i})))
    else $error("b_drop_o or its tags changed before b_done_i");

  a_beat_stable: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    (m_valid_i && !m_ready_i) |=> (m_valid_i && $stable(m_beat_i)))
    else $error("master beat changed while stalled");

  // Forwarding and dropping never overlap
  a_exclusive: assert property (@(posedge axi4_aclk) disable iff (!axi4_arstn)
    !(m_valid_i && b_drop_i))
    else $error("m_valid_o and b_drop_o high together");

endmodule

// File: verification/w_buffer_checker.sv
// Checker for the AXI4 write-data buffer
// Holds the expected beats and drops, compares every master transfer and
// every drop handshake, and prints per-test and summary lines

`timescale 1ns/1ps

module w_buffer_checker
  import w_buffer_pkg::*;
(
  input logic                  axi4_aclk,
  input logic                  axi4_arstn,
  input logic                  l1_done_i,
  input logic                  input_stall_i,
  input logic                  master_select_i,
  input logic                  b_drop_i,
  input logic [ID_WIDTH-1:0]   id_i,
  input logic                  prefetch_i,
  input logic                  hit_i,
  input logic                  s_wready_i,
  input logic [DATA_WIDTH-1:0] m_wdata_i,
  input logic [STRB_WIDTH-1:0] m_wstrb_i,
  input logic                  m_wlast_i,
  input logic [USER_WIDTH-1:0] m_wuser_i,
  input logic                  m_wvalid_i,
  input logic                  m_wready_i
);

  typedef struct packed {
    w_beat_t beat;
    logic    master;
  } exp_beat_t;

  exp_beat_t exp_beats [$];
  decision_t exp_drops [$];
  int        errors       = 0;
  int        test_start   = 0;
  int        tests        = 0;
  int        done_pulses  = 0;
  int        fwd_bursts   = 0;
  int        drop_periods = 0;
  w_beat_t   m_beat;
  w_beat_t   prev_beat    = '0;
  logic      prev_stall   = 1'b0;
  logic      prev_drop    = 1'b0;
  decision_t cur_drop     = '0;

  assign m_beat = {m_wdata_i, m_wstrb_i, m_wuser_i, m_wlast_i};

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report(input string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  task automatic expect_beat(input w_beat_t beat, input logic master);
    exp_beats.push_back({beat, master});
  endtask

  task automatic expect_drop(input decision_t dec);
    exp_drops.push_back(dec);
  endtask

  function automatic int pending();
    return exp_beats.size() + exp_drops.size();
  endfunction

  task automatic check_reset();
    compare("l1_done_o", 32'(l1_done_i), 0);
    compare("m_axi4_wvalid_o", 32'(m_wvalid_i), 0);
    compare("b_drop_o", 32'(b_drop_i), 0);
    compare("input_stall_o", 32'(input_stall_i), 0);
    compare("s_axi4_wready_o", 32'(s_wready_i), 1);
  endtask

  task automatic begin_test();
    test_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s: %s (%0d errors)", name,
             (errors == test_start) ? "ok" : "FAILED", errors - test_start);
  endtask

  task automatic summary();
    $display("%0d tests, %0d errors, %0d bursts forwarded, %0d drops, %0d decisions taken",
             tests, errors, fwd_bursts, drop_periods, done_pulses);
  endtask

  always @(posedge axi4_aclk) begin
    exp_beat_t e;
    if (axi4_arstn) begin
      if (l1_done_i) done_pulses++;
      if (m_wvalid_i && b_drop_i) report("master valid and b_drop_o high together");
      if (prev_stall && (!m_wvalid_i || m_beat !== prev_beat))
        report("master beat changed or vanished under back-pressure");
      if (m_wvalid_i && m_wready_i) begin
        if (exp_beats.size() == 0) begin
          report("unexpected beat on the master W channel");
        end else begin
          e = exp_beats.pop_front();
          compare("m_axi4_wdata_o", 32'(m_wdata_i), 32'(e.beat.data));
          compare("m_axi4_wstrb_o", 32'(m_wstrb_i), 32'(e.beat.strb));
          compare("m_axi4_wuser_o", 32'(m_wuser_i), 32'(e.beat.user));
          compare("m_axi4_wlast_o", 32'(m_wlast_i), 32'(e.beat.last));
          compare("master_select_o", 32'(master_select_i), 32'(e.master));
          if (m_wlast_i) fwd_bursts++;
        end
      end
      // A new drop period takes the next expected drop
      if (b_drop_i && !prev_drop) begin
        drop_periods++;
        if (exp_drops.size() == 0) report("unexpected b_drop_o period");
        else cur_drop = exp_drops.pop_front();
      end
      if (b_drop_i) begin
        compare("id_o", 32'(id_i), 32'(cur_drop.id));
        compare("prefetch_o", 32'(prefetch_i), 32'(cur_drop.prefetch));
        compare("hit_o", 32'(hit_i), 32'(cur_drop.hit));
      end
      prev_stall = m_wvalid_i && !m_wready_i;
      prev_beat  = m_beat;
      prev_drop  = b_drop_i;
    end
  end

endmodule

// File: verification/tb_axi4_w_buffer.sv
// Testbench for the AXI4 write-data buffer
// Random bursts with accept or drop decisions, random W gaps, random
// master back-pressure and a random B sender, all on the falling edge

`timescale 1ns/1ps

module tb_axi4_w_buffer;
  import w_buffer_pkg::*;

  localparam int TIMEOUT = 2000;
  localparam int RANDOM_BURSTS = 60;

  logic axi4_aclk = 1'b0;
  logic axi4_arstn = 1'b0;
  logic l1_accept_i = 1'b0, l1_drop_i = 1'b0, l1_master_i = 1'b0;
  logic [ID_WIDTH-1:0] l1_id_i = '0;
  logic l1_prefetch_i = 1'b0, l1_hit_i = 1'b0, b_done_i = 1'b0;
  logic l1_done_o, input_stall_o, master_select_o, b_drop_o, prefetch_o, hit_o;
  logic [ID_WIDTH-1:0] id_o;
  w_beat_t s_beat = '0;
  logic s_axi4_wvalid_i = 1'b0, s_axi4_wready_o, m_axi4_wready_i = 1'b0;
  logic [DATA_WIDTH-1:0] m_axi4_wdata_o;
  logic [STRB_WIDTH-1:0] m_axi4_wstrb_o;
  logic [USER_WIDTH-1:0] m_axi4_wuser_o;
  logic m_axi4_wlast_o, m_axi4_wvalid_o;

  int seed = 32'h4cf08f2b;
  int ready_pct = 100;
  int bdone_wait = 0;
  w_beat_t beat_q [$];
  decision_t dec_q [$];
  decision_t ninth;

  always #5 axi4_aclk = ~axi4_aclk;

  axi4_w_buffer dut_i (
    .axi4_aclk, .axi4_arstn, .l1_accept_i, .l1_drop_i, .l1_master_i, .l1_id_i,
    .l1_prefetch_i, .l1_hit_i, .l1_done_o, .input_stall_o, .master_select_o,
    .b_drop_o, .b_done_i, .id_o, .prefetch_o, .hit_o,
    .s_axi4_wdata_i(s_beat.data), .s_axi4_wstrb_i(s_beat.strb), .s_axi4_wlast_i(s_beat.last),
    .s_axi4_wuser_i(s_beat.user), .s_axi4_wvalid_i, .s_axi4_wready_o,
    .m_axi4_wdata_o, .m_axi4_wstrb_o, .m_axi4_wlast_o, .m_axi4_wuser_o,
    .m_axi4_wvalid_o, .m_axi4_wready_i
  );

  w_buffer_checker u_checker (
    .axi4_aclk, .axi4_arstn, .l1_done_i(l1_done_o), .input_stall_i(input_stall_o),
    .master_select_i(master_select_o), .b_drop_i(b_drop_o), .id_i(id_o),
    .prefetch_i(prefetch_o), .hit_i(hit_o), .s_wready_i(s_axi4_wready_o),
    .m_wdata_i(m_axi4_wdata_o), .m_wstrb_i(m_axi4_wstrb_o), .m_wlast_i(m_axi4_wlast_o),
    .m_wuser_i(m_axi4_wuser_o), .m_wvalid_i(m_axi4_wvalid_o), .m_wready_i(m_axi4_wready_i)
  );

  bind w_route_ctrl w_buffer_asserts u_asserts (
    .axi4_aclk, .axi4_arstn, .m_valid_i(m_valid_o), .m_ready_i, .m_beat_i(m_beat_o),
    .b_drop_i(b_drop_o), .b_done_i, .id_i(id_o), .prefetch_i(prefetch_o), .hit_i(hit_o)
  );

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    if (r < 0) r = -r;
    return r % n;
  endfunction

  task automatic abort(input string msg);
    $display("TIMEOUT: %s", msg);
    $display("sim failed");
    $finish;
  endtask

  // Master back-pressure and B sender answering after a random delay
  always @(negedge axi4_aclk) begin
    m_axi4_wready_i = (rand_below(100) < ready_pct);
    if (b_done_i) begin
      b_done_i = 1'b0;
    end else if (b_drop_o) begin
      if (bdone_wait == 0) begin
        bdone_wait = rand_below(4) + 1;
      end else begin
        bdone_wait--;
        if (bdone_wait == 0) b_done_i = 1'b1;
      end
    end
  end

  task automatic queue_burst(input logic accept);
    decision_t dec;
    w_beat_t b;
    int len;
    len = rand_below(8) + 1;
    dec = make_decision(accept, !accept, 1'(rand_below(2)), ID_WIDTH'(rand_below(16)),
                        1'(rand_below(2)), 1'(rand_below(2)));
    dec_q.push_back(dec);
    if (!accept) u_checker.expect_drop(dec);
    for (int i = 0; i < len; i++) begin
      b.data = $random(seed);
      b.strb = STRB_WIDTH'(rand_below(16));
      b.user = USER_WIDTH'(rand_below(16));
      b.last = (i == len - 1);
      beat_q.push_back(b);
      if (accept) u_checker.expect_beat(b, dec.master);
    end
  endtask

  task automatic drive_decision(input decision_t dec);
    int t;
    t = 0;
    {l1_accept_i, l1_drop_i, l1_master_i, l1_id_i, l1_prefetch_i, l1_hit_i} = dec;
    @(posedge axi4_aclk);
    while (!l1_done_o) begin
      t++;
      if (t > TIMEOUT) abort("l1_done_o never answered a decision");
      @(posedge axi4_aclk);
    end
    @(negedge axi4_aclk);
    l1_accept_i = 1'b0;
    l1_drop_i = 1'b0;
  endtask

  task automatic drive_decisions(input int count);
    for (int i = 0; i < count; i++) begin
      repeat (rand_below(4)) @(negedge axi4_aclk);
      drive_decision(dec_q.pop_front());
    end
  endtask

  task automatic drive_beats();
    int t;
    while (beat_q.size() > 0) begin
      repeat (rand_below(3)) @(negedge axi4_aclk);
      s_beat = beat_q.pop_front();
      s_axi4_wvalid_i = 1'b1;
      t = 0;
      @(posedge axi4_aclk);
      while (!s_axi4_wready_o) begin
        t++;
        if (t > TIMEOUT) abort("s_axi4_wready_o stayed low");
        @(posedge axi4_aclk);
      end
      @(negedge axi4_aclk);
      s_axi4_wvalid_i = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (u_checker.pending() != 0 || b_drop_o) begin
      t++;
      if (t > TIMEOUT) abort("expected beats or drops never arrived");
      @(negedge axi4_aclk);
    end
  endtask

  initial begin
    repeat (8) @(posedge axi4_aclk);
    @(negedge axi4_aclk);
    axi4_arstn = 1'b1;
    @(negedge axi4_aclk);
    u_checker.begin_test();
    u_checker.check_reset();
    u_checker.end_test("reset values");

    // Fill the decision FIFO before any W data arrives
    u_checker.begin_test();
    ready_pct = 60;
    for (int i = 0; i < 9; i++) queue_burst(1'b1);
    drive_decisions(8);
    u_checker.compare("l1_done_o pulses", 32'(u_checker.done_pulses), 8);
    u_checker.compare("input_stall_o", 32'(input_stall_o), 1);
    ninth = dec_q.pop_front();
    {l1_accept_i, l1_drop_i, l1_master_i, l1_id_i, l1_prefetch_i, l1_hit_i} = ninth;
    repeat (6) begin
      @(negedge axi4_aclk);
      u_checker.compare("l1_done_o while full", 32'(l1_done_o), 0);
    end
    fork
      begin
        drive_decision(ninth);
        u_checker.compare("bursts done before ninth l1_done_o",
                          32'(u_checker.fwd_bursts > 0), 1);
      end
      drive_beats();
    join
    wait_drain();
    u_checker.end_test("full decision fifo");

    u_checker.begin_test();
    ready_pct = 70;
    for (int i = 0; i < RANDOM_BURSTS; i++) queue_burst(1'(rand_below(2)));
    fork
      drive_decisions(RANDOM_BURSTS);
      drive_beats();
    join
    wait_drain();
    u_checker.end_test("random bursts");

    u_checker.summary();
    if (u_checker.errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: project.f
verilog/w_buffer_pkg.sv
verilog/w_beat_if.sv
verilog/w_stream_fifo.sv
verilog/w_route_ctrl.sv
verilog/axi4_w_buffer.sv
verification/w_buffer_asserts.sv
verification/w_buffer_checker.sv
verification/tb_axi4_w_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the write-data buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axi4_w_buffer -f project.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass message not found"
exit 1
